//--- design/pi_pkg.sv
/* widths, bus operation codes and memory-map constants shared by the design.
   imported by every module and by the bus interface. */
package pi_pkg;
	localparam int ARCH_W = 32;
	localparam int SEL_W = ARCH_W / 8;
	localparam int ADDR_W = ARCH_W - 2; // word address.
	localparam int CNT_W = 16;

	typedef logic [ARCH_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [SEL_W-1:0] sel_t;
	typedef logic [1:0] pi_op_t;
	typedef logic [CNT_W-1:0] cnt_t;

	localparam pi_op_t OP_NONE = 2'd0;
	localparam pi_op_t OP_WR = 2'd1;
	localparam pi_op_t OP_RD = 2'd2;
	localparam pi_op_t OP_RW = 2'd3;

	// map sizes in words, as reported by the device table.
	localparam addr_t TINY_MAP_SZ = 30'd2;
	localparam addr_t BLOCK_MAP_SZ = 30'd128;
	localparam addr_t DEVTBL_MAP_SZ = 30'd892;
	localparam addr_t RAM_SZ = 30'h0004_0000;
	localparam addr_t RAMCTRL_SZ = 30'd2;

	// system query answers.
	localparam word_t CACHE_SZ = 32'd4096;
	localparam word_t SOC_VERSION = 32'h0001_0002;
	localparam word_t PRELDR_ADDR = 32'h0000_1000;

	localparam addr_t SCRATCH_BASE = 30'd1024;
	localparam int SCRATCH_WORDS = 64;
	localparam int SCRATCH_AW = $clog2(SCRATCH_WORDS);
	typedef logic [SCRATCH_AW-1:0] ram_idx_t;

	localparam int FIFO_DEPTH = 8; // power of two.
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);
	typedef logic [FIFO_AW-1:0] fifo_ptr_t;
endpackage

//--- design/pi_bus_if.sv
/* one peripheral-interface bus between the dispatcher and a single device.
   ops are sampled in the cycle they are driven, rdata follows a cycle later. */
interface pi_bus_if
	import pi_pkg::*;
();
	pi_op_t op;
	addr_t addr;
	word_t wdata;
	sel_t sel;
	word_t rdata; // held until the next operation.

	modport master (
		output op,
		output addr,
		output wdata,
		output sel,
		input rdata
	);

	modport device (
		input op,
		input addr,
		input wdata,
		input sel,
		output rdata
	);
endinterface

//--- design/pi_host_port.sv
/* host side of the subsystem: turns request strobes into queue pushes.
   strobes that meet a full queue are dropped and counted. */
module pi_host_port
	import pi_pkg::*;
(
	input  logic   clk_i,
	input  logic   rst_i,
	input  logic   req_i,
	input  pi_op_t req_op_i,
	input  addr_t  req_addr_i,
	input  word_t  req_data_i,
	input  sel_t   req_sel_i,
	input  logic   full_i,
	output logic   push_o,
	output pi_op_t push_op_o,
	output addr_t  push_addr_o,
	output word_t  push_data_o,
	output sel_t   push_sel_o,
	output cnt_t   drop_cnt_o
);
	assign push_o = req_i && !full_i;
	assign push_op_o = req_op_i;
	assign push_addr_o = req_addr_i;
	assign push_data_o = req_data_i;
	assign push_sel_o = req_sel_i;

	// saturates at all ones.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			drop_cnt_o <= '0;
		end else if (req_i && full_i && !(&drop_cnt_o)) begin
			drop_cnt_o <= drop_cnt_o + 1'b1;
		end
	end
endmodule

//--- design/pi_req_fifo.sv
/* show-ahead request queue between host port and dispatcher.
   the head entry is valid whenever empty_o is low. */
module pi_req_fifo
	import pi_pkg::*;
(
	input  logic   clk_i,
	input  logic   rst_i,
	input  logic   push_i,
	input  pi_op_t push_op_i,
	input  addr_t  push_addr_i,
	input  word_t  push_data_i,
	input  sel_t   push_sel_i,
	input  logic   pop_i,
	output pi_op_t head_op_o,
	output addr_t  head_addr_o,
	output word_t  head_data_o,
	output sel_t   head_sel_o,
	output logic   empty_o,
	output logic   full_o
);
	pi_op_t op_mem [FIFO_DEPTH];
	addr_t addr_mem [FIFO_DEPTH];
	word_t data_mem [FIFO_DEPTH];
	sel_t sel_mem [FIFO_DEPTH];

	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;
	logic [FIFO_AW:0] count;

	// pushes are only offered when not full.
	always_ff @(posedge clk_i) begin
		if (push_i) begin
			op_mem[wr_ptr] <= push_op_i;
			addr_mem[wr_ptr] <= push_addr_i;
			data_mem[wr_ptr] <= push_data_i;
			sel_mem[wr_ptr] <= push_sel_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_i) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth.
			end
			if (pop_i) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push_i, pop_i})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head_op_o = op_mem[rd_ptr];
	assign head_addr_o = addr_mem[rd_ptr];
	assign head_data_o = data_mem[rd_ptr];
	assign head_sel_o = sel_mem[rd_ptr];

	assign empty_o = (count == '0);
	assign full_o = count[FIFO_AW]; // count reaches depth only when full.
endmodule

//--- design/pi_dispatch.sv
/* pops queued requests one at a time and issues them on the device buses.
   the cycle after an issue carries the response for reads. */
module pi_dispatch
	import pi_pkg::*;
(
	input  logic   clk_i,
	input  logic   rst_i,
	input  pi_op_t head_op_i,
	input  addr_t  head_addr_i,
	input  word_t  head_data_i,
	input  sel_t   head_sel_i,
	input  logic   empty_i,
	output logic   pop_o,
	pi_bus_if.master tbl_bus,
	pi_bus_if.master ram_bus,
	output logic   rsp_valid_o,
	output word_t  rsp_data_o
);
	logic issue;
	logic hit_tbl;
	logic hit_ram;
	logic reads;
	logic busy_q;
	logic rd_q;
	logic tbl_q;
	logic ram_q;
	addr_t ram_off;

	assign issue = !empty_i && !busy_q;
	assign pop_o = issue;

	assign ram_off = head_addr_i - SCRATCH_BASE;
	assign hit_tbl = head_addr_i < SCRATCH_BASE;
	assign hit_ram = !hit_tbl && (ram_off < addr_t'(SCRATCH_WORDS));
	assign reads = (head_op_i == OP_RD) || (head_op_i == OP_RW);

	// unselected buses see OP_NONE.
	always_comb begin
		tbl_bus.op = OP_NONE;
		tbl_bus.addr = head_addr_i;
		tbl_bus.wdata = head_data_i;
		tbl_bus.sel = head_sel_i;
		ram_bus.op = OP_NONE;
		ram_bus.addr = ram_off;
		ram_bus.wdata = head_data_i;
		ram_bus.sel = head_sel_i;
		if (issue) begin
			if (hit_tbl) begin
				tbl_bus.op = head_op_i;
			end else if (hit_ram) begin
				ram_bus.op = head_op_i;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_q <= 1'b0;
			rd_q <= 1'b0;
			tbl_q <= 1'b0;
			ram_q <= 1'b0;
		end else begin
			busy_q <= issue; // response cycle.
			rd_q <= issue && reads;
			if (issue) begin
				tbl_q <= hit_tbl;
				ram_q <= hit_ram;
			end
		end
	end

	assign rsp_valid_o = rd_q;
	assign rsp_data_o = tbl_q ? tbl_bus.rdata : (ram_q ? ram_bus.rdata : '0);
endmodule

//--- design/dev_tbl.sv
/* device table: describes the memory map, answers system queries
   and takes reset commands through OP_RW at words 0 and 1. */
module dev_tbl
	import pi_pkg::*;
(
	input  logic clk_i,
	input  logic rst_i,
	pi_bus_if.device bus,
	output logic rst0_o,
	output logic rst1_o,
	output logic rst2_o
);
	logic preldr_taken_q; // sticky until reset.

	// even words hold the kind, odd words the size with a flag in bit 0.
	function automatic word_t tbl_word(input addr_t a);
		case (a)
			addr_t'(0): return 32'd4;
			addr_t'(1): return {BLOCK_MAP_SZ, 2'b01};
			addr_t'(2): return 32'd7;
			addr_t'(3): return {DEVTBL_MAP_SZ, 2'b00};
			addr_t'(4): return 32'd3;
			addr_t'(5): return {TINY_MAP_SZ, 2'b00};
			addr_t'(6): return 32'd5;
			addr_t'(7): return {TINY_MAP_SZ, 2'b01};
			addr_t'(8): return 32'd1;
			addr_t'(9): return {RAM_SZ, 2'b00};
			addr_t'(10): return 32'd0;
			addr_t'(11): return {RAMCTRL_SZ, 2'b00};
			default: return '0;
		endcase
	endfunction

	function automatic word_t query(input word_t idx, input logic r1, input logic r0,
			input logic taken);
		case (idx)
			32'd0: return SOC_VERSION;
			32'd1: return CACHE_SZ;
			32'd2: return {30'd0, r1, r0};
			32'd3: return taken ? '0 : PRELDR_ADDR;
			default: return '0;
		endcase
	endfunction

	// reset commands.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rst0_o <= 1'b0;
			rst1_o <= 1'b0;
			rst2_o <= 1'b0;
			preldr_taken_q <= 1'b0;
		end else begin
			rst2_o <= 1'b0; // one-cycle pulse.
			if (bus.op == OP_RW && bus.addr == addr_t'(1)) begin
				case (bus.wdata)
					32'd0: begin
						rst0_o <= 1'b1;
						rst1_o <= 1'b0;
					end
					32'd1: begin
						rst0_o <= 1'b0;
						rst1_o <= 1'b1;
					end
					32'd2: begin
						rst0_o <= 1'b1;
						rst1_o <= 1'b1;
					end
					32'd3: begin
						preldr_taken_q <= 1'b1;
						rst2_o <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	// read data, held between operations.
	always_ff @(posedge clk_i) begin
		if (bus.op == OP_RD) begin
			bus.rdata <= tbl_word(bus.addr);
		end else if (bus.op == OP_RW) begin
			if (bus.addr == addr_t'(0)) begin
				bus.rdata <= query(bus.wdata, rst1_o, rst0_o, preldr_taken_q);
			end else begin
				bus.rdata <= '0; // commands return zero.
			end
		end
	end
endmodule

//--- design/scratch_ram.sv
/* small scratch memory on its own bus, with byte-select writes.
   reads return the word as it was before a same-cycle write. */
module scratch_ram
	import pi_pkg::*;
(
	input logic clk_i,
	input logic rst_i,
	pi_bus_if.device bus
);
	word_t mem [SCRATCH_WORDS];
	ram_idx_t idx;
	logic wr_en;
	logic rd_en;

	assign idx = bus.addr[SCRATCH_AW-1:0]; // offset from the window base.
	assign wr_en = (bus.op == OP_WR) || (bus.op == OP_RW);
	assign rd_en = (bus.op == OP_RD) || (bus.op == OP_RW);

	always_ff @(posedge clk_i) begin
		if (wr_en) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (bus.sel[b]) begin
					mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			bus.rdata <= '0;
		end else if (rd_en) begin
			bus.rdata <= mem[idx]; // old word.
		end
	end
endmodule

//--- design/pi_subsys_top.sv
/* subsystem top: host port, request queue, dispatcher and the two devices.
   the host drives request strobes and receives response pulses. */
module pi_subsys_top
	import pi_pkg::*;
(
	input  logic   clk_i,
	input  logic   rst_i,
	input  logic   req_i,
	input  pi_op_t req_op_i,
	input  addr_t  req_addr_i,
	input  word_t  req_data_i,
	input  sel_t   req_sel_i,
	output logic   rsp_valid_o,
	output word_t  rsp_data_o,
	output cnt_t   drop_cnt_o,
	output logic   rst0_o,
	output logic   rst1_o,
	output logic   rst2_o
);
	logic push;
	logic pop;
	logic empty;
	logic full;
	pi_op_t push_op;
	pi_op_t head_op;
	addr_t push_addr;
	addr_t head_addr;
	word_t push_data;
	word_t head_data;
	sel_t push_sel;
	sel_t head_sel;

	pi_bus_if tbl_bus ();
	pi_bus_if ram_bus ();

	pi_host_port u_host (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.req_i       (req_i),
		.req_op_i    (req_op_i),
		.req_addr_i  (req_addr_i),
		.req_data_i  (req_data_i),
		.req_sel_i   (req_sel_i),
		.full_i      (full),
		.push_o      (push),
		.push_op_o   (push_op),
		.push_addr_o (push_addr),
		.push_data_o (push_data),
		.push_sel_o  (push_sel),
		.drop_cnt_o  (drop_cnt_o)
	);

	pi_req_fifo u_fifo (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.push_i      (push),
		.push_op_i   (push_op),
		.push_addr_i (push_addr),
		.push_data_i (push_data),
		.push_sel_i  (push_sel),
		.pop_i       (pop),
		.head_op_o   (head_op),
		.head_addr_o (head_addr),
		.head_data_o (head_data),
		.head_sel_o  (head_sel),
		.empty_o     (empty),
		.full_o      (full)
	);

	pi_dispatch u_disp (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.head_op_i   (head_op),
		.head_addr_i (head_addr),
		.head_data_i (head_data),
		.head_sel_i  (head_sel),
		.empty_i     (empty),
		.pop_o       (pop),
		.tbl_bus     (tbl_bus.master),
		.ram_bus     (ram_bus.master),
		.rsp_valid_o (rsp_valid_o),
		.rsp_data_o  (rsp_data_o)
	);

	dev_tbl u_tbl (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.bus    (tbl_bus.device),
		.rst0_o (rst0_o),
		.rst1_o (rst1_o),
		.rst2_o (rst2_o)
	);

	scratch_ram u_ram (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.bus   (ram_bus.device)
	);
endmodule

//--- sim/tb_pi_subsys.sv
/* testbench for the peripheral-bus subsystem: table, queries, reset commands,
   scratch RAM and queue overflow, checked against a model of the memory map. */
module tb_pi_subsys
	import pi_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_RAND = 48;
	localparam int BURST_LEN = 20;
	localparam int N_REQ = 14 + 5 + 8 + 2 * SCRATCH_WORDS + N_RAND + 3 + BURST_LEN;
	localparam int WATCHDOG_CYCLES = N_REQ * 4 + 10 + 100;

	logic clk_i;
	logic rst_i;
	logic req_i;
	pi_op_t req_op_i;
	addr_t req_addr_i;
	word_t req_data_i;
	sel_t req_sel_i;
	logic rsp_valid_o;
	word_t rsp_data_o;
	cnt_t drop_cnt_o;
	logic rst0_o;
	logic rst1_o;
	logic rst2_o;

	word_t exp_q [$];
	word_t ram_model [SCRATCH_WORDS];
	word_t exp_cur; // expected data for the strobe being driven.
	word_t pend_exp;
	logic pend_rd;
	cnt_t pend_drop;
	word_t lcg_state;
	int errors;
	int rsp_cnt;
	int rst2_cycles;

	pi_subsys_top dut (.*);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	function automatic word_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// kinds on even words, size << 2 with flag on odd words.
	function automatic word_t tbl_expect(input int w);
		word_t kind [6];
		addr_t size [6];
		logic flag [6];
		kind = '{32'd4, 32'd7, 32'd3, 32'd5, 32'd1, 32'd0};
		size = '{BLOCK_MAP_SZ, DEVTBL_MAP_SZ, TINY_MAP_SZ, TINY_MAP_SZ, RAM_SZ, RAMCTRL_SZ};
		flag = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
		if (w > 11) return '0;
		if (w % 2 == 0) return kind[w / 2];
		return {size[w / 2], 1'b0, flag[w / 2]};
	endfunction

	function automatic word_t merge_bytes(input word_t old, input word_t wdata, input sel_t sel);
		word_t res;
		res = old;
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b]) res[8*b +: 8] = wdata[8*b +: 8];
		end
		return res;
	endfunction

	task automatic report_mismatch(input string name, input word_t got, input word_t exp);
		errors++;
		$display("Error: %s got %h expected %h", name, got, exp);
	endtask

	task automatic drive_req(input pi_op_t op, input addr_t addr, input word_t data,
			input sel_t sel, input word_t exp);
		@(posedge clk_i);
		req_i <= 1'b1;
		req_op_i <= op;
		req_addr_i <= addr;
		req_data_i <= data;
		req_sel_i <= sel;
		exp_cur <= exp;
	endtask

	task automatic idle_cycle();
		@(posedge clk_i);
		req_i <= 1'b0;
	endtask

	task automatic send(input pi_op_t op, input addr_t addr, input word_t data,
			input sel_t sel, input word_t exp);
		drive_req(op, addr, data, sel, exp);
		idle_cycle();
	endtask

	task automatic wait_rsp();
		int n;
		n = 0;
		@(negedge clk_i);
		while (!rsp_valid_o && n < 8) begin
			@(negedge clk_i);
			n++;
		end
		if (!rsp_valid_o) begin
			errors++;
			$display("no response arrived within 8 cycles of a request");
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		repeat (2) @(negedge clk_i); // lets the monitor record the last strobe.
		while (exp_q.size() > 0 && n < 40) begin
			@(negedge clk_i);
			n++;
		end
		if (exp_q.size() > 0) begin
			errors++;
			$display("%0d expected responses never arrived", exp_q.size());
		end
	endtask

	task automatic check_rsp();
		rsp_cnt++;
		assert (exp_q.size() > 0) else begin
			errors++;
			$display("response arrived with no read outstanding");
		end
		if (exp_q.size() > 0) begin
			assert (rsp_data_o == exp_q[0])
				else report_mismatch("rsp_data_o", rsp_data_o, exp_q[0]);
			void'(exp_q.pop_front());
		end
	endtask

	// a read strobe counts as accepted when drop_cnt_o did not move.
	always @(negedge clk_i) begin
		if (rst_i) begin
			pend_rd = 1'b0;
		end else begin
			if (pend_rd && drop_cnt_o == pend_drop) exp_q.push_back(pend_exp);
			if (rsp_valid_o) check_rsp();
			if (rst2_o) rst2_cycles++;
			pend_rd = req_i && (req_op_i == OP_RD || req_op_i == OP_RW);
			pend_exp = exp_cur;
			pend_drop = drop_cnt_o;
		end
	end

	task automatic reset_cmd(input word_t cmd, input logic exp_r0, input logic exp_r1);
		send(OP_RW, addr_t'(1), cmd, 4'hf, '0);
		wait_rsp();
		assert (rst0_o == exp_r0)
			else report_mismatch("rst0_o", word_t'(rst0_o), word_t'(exp_r0));
		assert (rst1_o == exp_r1)
			else report_mismatch("rst1_o", word_t'(rst1_o), word_t'(exp_r1));
		send(OP_RW, addr_t'(0), 32'd2, 4'hf, {30'd0, exp_r1, exp_r0});
		drain();
	endtask

	task automatic ram_random_test();
		word_t r;
		word_t data;
		word_t exp;
		sel_t sel;
		pi_op_t op;
		int idx;
		for (int i = 0; i < SCRATCH_WORDS; i++) begin
			data = 32'h3c00_0000 ^ (word_t'(i) * 32'h0104_0801);
			ram_model[i] = data;
			send(OP_WR, SCRATCH_BASE + addr_t'(i), data, 4'hf, '0);
		end
		for (int i = 0; i < N_RAND; i++) begin
			r = lcg_next();
			data = lcg_next();
			idx = int'(r[21:16]);
			sel = r[11:8];
			case (r[31:30])
				2'd0: op = OP_WR;
				2'd1: op = OP_RD;
				default: op = OP_RW;
			endcase
			exp = ram_model[idx]; // old word for RD and RW.
			if (op != OP_RD) ram_model[idx] = merge_bytes(ram_model[idx], data, sel);
			send(op, SCRATCH_BASE + addr_t'(idx), data, sel, exp);
		end
		for (int i = 0; i < SCRATCH_WORDS; i++) begin
			send(OP_RD, SCRATCH_BASE + addr_t'(i), lcg_next(), 4'hf, ram_model[i]);
		end
		drain();
	endtask

	task automatic burst_test();
		int rsp_before;
		int drop_before;
		int total;
		rsp_before = rsp_cnt;
		drop_before = int'(drop_cnt_o);
		for (int i = 0; i < BURST_LEN; i++) begin
			drive_req(OP_RD, addr_t'(i % 12), lcg_next(), sel_t'(lcg_next()),
				tbl_expect(i % 12));
		end
		idle_cycle();
		drain();
		total = rsp_cnt - rsp_before + int'(drop_cnt_o) - drop_before;
		assert (total == BURST_LEN) else begin
			errors++;
			$display("burst gave %0d responses plus drops instead of %0d", total, BURST_LEN);
		end
		assert (drop_cnt_o != '0) else begin
			errors++;
			$display("drop_cnt_o stayed zero after the burst overflowed the queue");
		end
	endtask

	initial begin
		rst_i = 1'b1;
		req_i = 1'b0;
		req_op_i = OP_NONE;
		req_addr_i = '0;
		req_data_i = '0;
		req_sel_i = '0;
		exp_cur = '0;
		pend_exp = '0;
		pend_rd = 1'b0;
		pend_drop = '0;
		lcg_state = 32'd72166;
		errors = 0;
		rsp_cnt = 0;
		rst2_cycles = 0;
		repeat (10) @(posedge clk_i);
		rst_i <= 1'b0;
		@(negedge clk_i);
		assert (!rst0_o && !rst1_o && !rst2_o) else begin
			errors++;
			$display("reset outputs not low after reset");
		end
		assert (drop_cnt_o == '0) else report_mismatch("drop_cnt_o", word_t'(drop_cnt_o), '0);

		for (int w = 0; w < 14; w++) begin
			send(OP_RD, addr_t'(w), lcg_next(), 4'hf, tbl_expect(w));
		end
		send(OP_RW, addr_t'(0), 32'd0, 4'hf, SOC_VERSION);
		send(OP_RW, addr_t'(0), 32'd1, 4'hf, CACHE_SZ);
		send(OP_RW, addr_t'(0), 32'd2, 4'hf, '0);
		send(OP_RW, addr_t'(0), 32'd3, 4'hf, PRELDR_ADDR);
		send(OP_RW, addr_t'(0), 32'd4, 4'hf, '0);
		drain();

		reset_cmd(32'd0, 1'b1, 1'b0);
		reset_cmd(32'd1, 1'b0, 1'b1);
		reset_cmd(32'd2, 1'b1, 1'b1);
		send(OP_RW, addr_t'(1), 32'd3, 4'hf, '0);
		wait_rsp(); // response cycle is the cycle after issue.
		assert (rst2_o) else report_mismatch("rst2_o", word_t'(rst2_o), 32'd1);
		@(negedge clk_i);
		assert (!rst2_o) else report_mismatch("rst2_o", word_t'(rst2_o), '0);
		send(OP_RW, addr_t'(0), 32'd3, 4'hf, '0);
		drain();

		ram_random_test();

		send(OP_RD, SCRATCH_BASE + addr_t'(SCRATCH_WORDS), lcg_next(), 4'hf, '0);
		send(OP_RD, addr_t'(2000), lcg_next(), 4'hf, '0);
		send(OP_RD, '1, lcg_next(), 4'hf, '0);
		drain();
		burst_test();

		assert (rst2_cycles == 1) else report_mismatch("rst2_o cycles", rst2_cycles, 32'd1);
		$display("checks done: %0d errors, %0d responses, %0d drops", errors, rsp_cnt,
			drop_cnt_o);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		$display("watchdog expired after %0d cycles with tests still running", WATCHDOG_CYCLES);
		$display("sim failed");
		$finish;
	end
endmodule

//--- flist.f
design/pi_pkg.sv
design/pi_bus_if.sv
design/pi_host_port.sv
design/pi_req_fifo.sv
design/pi_dispatch.sv
design/dev_tbl.sv
design/scratch_ram.sv
design/pi_subsys_top.sv
sim/tb_pi_subsys.sv

//--- Makefile
OBJ = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module tb_pi_subsys -Mdir $(OBJ)

run: compile
	./$(OBJ)/Vtb_pi_subsys | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
